//--- cache_adapter_macros.svh
`ifndef CACHE_ADAPTER_MACROS_SVH
`define CACHE_ADAPTER_MACROS_SVH

// data bus between memory side and cache
`define CA_DATA_WIDTH 64
`define CA_DATA_BYTES 8

// byte address
`define CA_ADDR_WIDTH 28

// cache geometry
`define CA_SETS 8
`define CA_WAYS 2
`define CA_BLOCK_BYTES 64
`define CA_BLOCK_OFFSET_WIDTH $clog2(`CA_BLOCK_BYTES)

// one TAGST per block at init
`define CA_BLOCKS (`CA_SETS * `CA_WAYS)
// wide enough to hold CA_BLOCKS itself
`define CA_BLOCK_CNT_WIDTH 5

// commands in flight to the cache
`define CA_OUTSTANDING 4

`endif

//--- cache_adapter_pkg.sv
`include "cache_adapter_macros.svh"

package cache_adapter_pkg;

  typedef enum logic [2:0] {
    e_mem_rd    = 3'd0,
    e_mem_uc_rd = 3'd1,
    e_mem_wr    = 3'd2,
    e_mem_uc_wr = 3'd3,
    e_mem_amo   = 3'd4
  } mem_msg_type_e;

  // code n means 2^n bytes
  typedef enum logic [2:0] {
    e_size_1 = 3'd0,
    e_size_2 = 3'd1,
    e_size_4 = 3'd2,
    e_size_8 = 3'd3
  } mem_size_e;

  typedef enum logic [3:0] {
    e_store   = 4'd0,
    e_amoswap = 4'd1,
    e_amoadd  = 4'd2,
    e_amoxor  = 4'd3,
    e_amoand  = 4'd4,
    e_amoor   = 4'd5,
    e_amomin  = 4'd6,
    e_amomax  = 4'd7,
    e_amominu = 4'd8,
    e_amomaxu = 4'd9
  } mem_subop_e;

  typedef struct packed {
    mem_msg_type_e             msg_type;
    mem_subop_e                subop;
    mem_size_e                 size;
    logic [`CA_ADDR_WIDTH-1:0] addr;
  } mem_header_s;

  // encodings follow the cache's own opcode map
  typedef enum logic [5:0] {
    LB        = 6'b000000,
    LH        = 6'b000001,
    LW        = 6'b000010,
    LD        = 6'b000011,
    SB        = 6'b001000,
    SH        = 6'b001001,
    SW        = 6'b001010,
    SD        = 6'b001011,
    TAGST     = 6'b010000,
    AMOSWAP_W = 6'b100000,
    AMOADD_W  = 6'b100001,
    AMOXOR_W  = 6'b100010,
    AMOAND_W  = 6'b100011,
    AMOOR_W   = 6'b100100,
    AMOMIN_W  = 6'b100101,
    AMOMAX_W  = 6'b100110,
    AMOMINU_W = 6'b100111,
    AMOMAXU_W = 6'b101000,
    AMOSWAP_D = 6'b110000,
    AMOADD_D  = 6'b110001,
    AMOXOR_D  = 6'b110010,
    AMOAND_D  = 6'b110011,
    AMOOR_D   = 6'b110100,
    AMOMIN_D  = 6'b110101,
    AMOMAX_D  = 6'b110110,
    AMOMINU_D = 6'b110111,
    AMOMAXU_D = 6'b111000
  } cache_opcode_e;

  typedef struct packed {
    cache_opcode_e             opcode;
    logic [`CA_ADDR_WIDTH-1:0] addr;
    logic [`CA_DATA_WIDTH-1:0] data;
    logic [`CA_DATA_BYTES-1:0] mask;
  } cache_pkt_s;

  // low 2^size bytes copied across the whole bus
  function automatic logic [`CA_DATA_WIDTH-1:0] replicate_by_size(
    input logic [`CA_DATA_WIDTH-1:0] data,
    input mem_size_e                 size
  );
    logic [`CA_DATA_WIDTH-1:0] rep;
    case (size)
      e_size_1: rep = {8{data[7:0]}};
      e_size_2: rep = {4{data[15:0]}};
      e_size_4: rep = {2{data[31:0]}};
      default:  rep = data;
    endcase
    return rep;
  endfunction

endpackage

//--- mem_cmd_decode.sv
`timescale 1ns/1ps
`include "cache_adapter_macros.svh"

module mem_cmd_decode
  import cache_adapter_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  mem_header_s               mem_cmd_header_i,
  input  logic [`CA_DATA_WIDTH-1:0] mem_cmd_data_i,
  input  logic                      mem_cmd_v_i,
  output logic                      mem_cmd_ready_and_o,
  output logic                      dec_v_o,
  output cache_pkt_s                dec_pkt_o,
  output mem_header_s               dec_hdr_o,
  input  logic                      dec_yumi_i
);

  mem_header_s               hdr_r;
  logic [`CA_DATA_WIDTH-1:0] data_r;
  logic                      v_r;
  logic                      run_r;
  logic                      cmd_take;
  logic                      is_word;
  logic [2:0]                offset;
  logic [`CA_DATA_BYTES-1:0] mask;
  cache_opcode_e             opcode;

  // run_r keeps ready low until the first cycle after reset
  assign mem_cmd_ready_and_o = run_r & (~v_r | dec_yumi_i);
  assign cmd_take = mem_cmd_v_i & mem_cmd_ready_and_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      run_r <= 1'b0;
      v_r   <= 1'b0;
    end
    else
    begin
      run_r <= 1'b1;
      if (cmd_take)
        v_r <= 1'b1;
      else if (dec_yumi_i)
        v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_take)
    begin
      hdr_r  <= mem_cmd_header_i;
      data_r <= mem_cmd_data_i;
    end
  end

  assign is_word = (hdr_r.size == e_size_4);
  assign offset  = hdr_r.addr[2:0];

  always_comb
  begin
    opcode = LB;
    case (hdr_r.msg_type)
      e_mem_rd, e_mem_uc_rd:
        case (hdr_r.size)
          e_size_1: opcode = LB;
          e_size_2: opcode = LH;
          e_size_4: opcode = LW;
          e_size_8: opcode = LD;
          default:  opcode = LB;
        endcase
      e_mem_wr, e_mem_uc_wr, e_mem_amo:
        case (hdr_r.size)
          e_size_1: opcode = SB;
          e_size_2: opcode = SH;
          e_size_4, e_size_8:
            case (hdr_r.subop)
              e_store:   opcode = is_word ? SW : SD;
              e_amoswap: opcode = is_word ? AMOSWAP_W : AMOSWAP_D;
              e_amoadd:  opcode = is_word ? AMOADD_W : AMOADD_D;
              e_amoxor:  opcode = is_word ? AMOXOR_W : AMOXOR_D;
              e_amoand:  opcode = is_word ? AMOAND_W : AMOAND_D;
              e_amoor:   opcode = is_word ? AMOOR_W : AMOOR_D;
              e_amomin:  opcode = is_word ? AMOMIN_W : AMOMIN_D;
              e_amomax:  opcode = is_word ? AMOMAX_W : AMOMAX_D;
              e_amominu: opcode = is_word ? AMOMINU_W : AMOMINU_D;
              e_amomaxu: opcode = is_word ? AMOMAXU_W : AMOMAXU_D;
              default:   opcode = LB;
            endcase
          default: opcode = LB;
        endcase
      default: opcode = LB;
    endcase
  end

  // byte enables at the size-aligned offset
  always_comb
  begin
    case (hdr_r.size)
      e_size_1: mask = 8'h01 << offset;
      e_size_2: mask = 8'h03 << {offset[2:1], 1'b0};
      e_size_4: mask = 8'h0f << {offset[2], 2'b00};
      default:  mask = '1;
    endcase
  end

  assign dec_v_o          = v_r;
  assign dec_hdr_o        = hdr_r;
  assign dec_pkt_o.opcode = opcode;
  assign dec_pkt_o.addr   = hdr_r.addr;
  assign dec_pkt_o.data   = replicate_by_size(data_r, hdr_r.size);
  assign dec_pkt_o.mask   = mask;

endmodule

//--- cache_issue_ctrl.sv
`timescale 1ns/1ps
`include "cache_adapter_macros.svh"

module cache_issue_ctrl
  import cache_adapter_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       dec_v_i,
  input  cache_pkt_s dec_pkt_i,
  output logic       dec_yumi_o,
  output cache_pkt_s cache_pkt_o,
  output logic       cache_pkt_v_o,
  input  logic       cache_pkt_ready_and_i,
  input  logic       cache_data_v_i,
  output logic       clear_yumi_o,
  input  logic       fifo_ready_i,
  output logic       fifo_push_o,
  output logic       clear_done_o
);

  typedef enum logic [1:0] {
    e_reset,
    e_clear,
    e_ready
  } state_e;

  state_e                         state_r;
  state_e                         state_n;
  logic [`CA_BLOCK_CNT_WIDTH-1:0] sent_r;
  logic [`CA_BLOCK_CNT_WIDTH-1:0] recv_r;
  logic                           sent_all;
  logic                           recv_all;
  logic                           pkt_fire;

  assign sent_all = (sent_r == `CA_BLOCK_CNT_WIDTH'(`CA_BLOCKS));
  assign recv_all = (recv_r == `CA_BLOCK_CNT_WIDTH'(`CA_BLOCKS));
  assign pkt_fire = cache_pkt_v_o & cache_pkt_ready_and_i;

  always_comb
  begin
    state_n       = state_r;
    cache_pkt_o   = '0;
    cache_pkt_v_o = 1'b0;
    dec_yumi_o    = 1'b0;
    clear_yumi_o  = 1'b0;
    case (state_r)
      e_reset: state_n = e_clear;
      e_clear:
      begin
        // one TAGST per block, block counter selects the line
        cache_pkt_o.opcode = TAGST;
        cache_pkt_o.addr   = `CA_ADDR_WIDTH'(sent_r) << `CA_BLOCK_OFFSET_WIDTH;
        cache_pkt_v_o      = ~sent_all;
        // tag returns are dropped here, no response goes out
        clear_yumi_o       = cache_data_v_i;
        if (sent_all & recv_all)
          state_n = e_ready;
      end
      e_ready:
      begin
        cache_pkt_o   = dec_pkt_i;
        cache_pkt_v_o = dec_v_i & fifo_ready_i;
        dec_yumi_o    = pkt_fire;
      end
      default: state_n = e_reset;
    endcase
  end

  // header queued only once the cache takes the packet
  assign fifo_push_o  = dec_yumi_o;
  assign clear_done_o = (state_r == e_ready);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_reset;
      sent_r  <= '0;
      recv_r  <= '0;
    end
    else
    begin
      state_r <= state_n;
      if (state_r == e_clear)
      begin
        sent_r <= sent_r + pkt_fire;
        recv_r <= recv_r + clear_yumi_o;
      end
    end
  end

endmodule

//--- pending_hdr_fifo.sv
`timescale 1ns/1ps
`include "cache_adapter_macros.svh"

module pending_hdr_fifo
  import cache_adapter_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  mem_header_s data_i,
  input  logic        v_i,
  output logic        ready_o,
  output mem_header_s data_o,
  output logic        v_o,
  input  logic        yumi_i
);

  localparam int DEPTH = `CA_OUTSTANDING;
  localparam int PTR_W = $clog2(DEPTH);

  mem_header_s      mem_r [DEPTH];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [PTR_W:0]   count_r;
  logic             push;
  logic             pop;

  assign ready_o = (count_r != (PTR_W + 1)'(DEPTH));
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];
  assign push    = v_i & ready_o;
  assign pop     = yumi_i & v_o;

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_r[wr_ptr_r] <= data_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      if (pop)
        rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      // simultaneous push and pop leaves the count alone
      if (push & ~pop)
        count_r <= count_r + 1'b1;
      else if (pop & ~push)
        count_r <= count_r - 1'b1;
    end
  end

endmodule

//--- mem_resp_pack.sv
`timescale 1ns/1ps
`include "cache_adapter_macros.svh"

module mem_resp_pack
  import cache_adapter_pkg::*;
(
  input  mem_header_s               hdr_i,
  input  logic                      hdr_v_i,
  output logic                      hdr_yumi_o,
  input  logic                      clear_done_i,
  input  logic                      clear_yumi_i,
  input  logic [`CA_DATA_WIDTH-1:0] cache_data_i,
  input  logic                      cache_data_v_i,
  output logic                      cache_data_yumi_o,
  output mem_header_s               mem_resp_header_o,
  output logic [`CA_DATA_WIDTH-1:0] mem_resp_data_o,
  output logic                      mem_resp_v_o,
  input  logic                      mem_resp_ready_and_i
);

  logic resp_fire;

  // returns are in order, so the head header owns the current data word
  assign mem_resp_v_o = clear_done_i & hdr_v_i & cache_data_v_i;
  assign resp_fire    = mem_resp_v_o & mem_resp_ready_and_i;

  assign mem_resp_header_o = hdr_i;
  // the cache returns the value at the lsbs
  assign mem_resp_data_o   = replicate_by_size(cache_data_i, hdr_i.size);

  assign hdr_yumi_o = resp_fire;

  // tag-clear returns are consumed through the same yumi
  assign cache_data_yumi_o = resp_fire | clear_yumi_i;

endmodule

//--- cce_to_cache.sv
`timescale 1ns/1ps
`include "cache_adapter_macros.svh"

module cce_to_cache
  import cache_adapter_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,

  input  mem_header_s               mem_cmd_header_i,
  input  logic [`CA_DATA_WIDTH-1:0] mem_cmd_data_i,
  input  logic                      mem_cmd_v_i,
  output logic                      mem_cmd_ready_and_o,

  output mem_header_s               mem_resp_header_o,
  output logic [`CA_DATA_WIDTH-1:0] mem_resp_data_o,
  output logic                      mem_resp_v_o,
  input  logic                      mem_resp_ready_and_i,

  output cache_pkt_s                cache_pkt_o,
  output logic                      cache_pkt_v_o,
  input  logic                      cache_pkt_ready_and_i,

  input  logic [`CA_DATA_WIDTH-1:0] cache_data_i,
  input  logic                      cache_data_v_i,
  output logic                      cache_data_yumi_o
);

  logic        dec_v;
  cache_pkt_s  dec_pkt;
  mem_header_s dec_hdr;
  logic        dec_yumi;
  logic        clear_yumi;
  logic        clear_done;
  logic        fifo_ready;
  logic        fifo_push;
  mem_header_s fifo_hdr;
  logic        fifo_v;
  logic        fifo_yumi;

  mem_cmd_decode u_mem_cmd_decode (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .mem_cmd_header_i    (mem_cmd_header_i),
    .mem_cmd_data_i      (mem_cmd_data_i),
    .mem_cmd_v_i         (mem_cmd_v_i),
    .mem_cmd_ready_and_o (mem_cmd_ready_and_o),
    .dec_v_o             (dec_v),
    .dec_pkt_o           (dec_pkt),
    .dec_hdr_o           (dec_hdr),
    .dec_yumi_i          (dec_yumi)
  );

  cache_issue_ctrl u_cache_issue_ctrl (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .dec_v_i               (dec_v),
    .dec_pkt_i             (dec_pkt),
    .dec_yumi_o            (dec_yumi),
    .cache_pkt_o           (cache_pkt_o),
    .cache_pkt_v_o         (cache_pkt_v_o),
    .cache_pkt_ready_and_i (cache_pkt_ready_and_i),
    .cache_data_v_i        (cache_data_v_i),
    .clear_yumi_o          (clear_yumi),
    .fifo_ready_i          (fifo_ready),
    .fifo_push_o           (fifo_push),
    .clear_done_o          (clear_done)
  );

  // headers wait here until their data comes back
  pending_hdr_fifo u_pending_hdr_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (dec_hdr),
    .v_i     (fifo_push),
    .ready_o (fifo_ready),
    .data_o  (fifo_hdr),
    .v_o     (fifo_v),
    .yumi_i  (fifo_yumi)
  );

  mem_resp_pack u_mem_resp_pack (
    .hdr_i                (fifo_hdr),
    .hdr_v_i              (fifo_v),
    .hdr_yumi_o           (fifo_yumi),
    .clear_done_i         (clear_done),
    .clear_yumi_i         (clear_yumi),
    .cache_data_i         (cache_data_i),
    .cache_data_v_i       (cache_data_v_i),
    .cache_data_yumi_o    (cache_data_yumi_o),
    .mem_resp_header_o    (mem_resp_header_o),
    .mem_resp_data_o      (mem_resp_data_o),
    .mem_resp_v_o         (mem_resp_v_o),
    .mem_resp_ready_and_i (mem_resp_ready_and_i)
  );

endmodule

//--- tb_cce_to_cache.sv
`timescale 1ns/1ps
`include "cache_adapter_macros.svh"

module tb_cce_to_cache
  import cache_adapter_pkg::*;
();

  localparam int          WAIT_LIMIT = 400;
  localparam logic [63:0] RET_XOR    = 64'h5a5a_0000_1234_0000;

  logic                      clk_i;
  logic                      reset_i;
  mem_header_s               mem_cmd_header_i;
  logic [`CA_DATA_WIDTH-1:0] mem_cmd_data_i;
  logic                      mem_cmd_v_i;
  logic                      mem_cmd_ready_and_o;
  mem_header_s               mem_resp_header_o;
  logic [`CA_DATA_WIDTH-1:0] mem_resp_data_o;
  logic                      mem_resp_v_o;
  logic                      mem_resp_ready_and_i;
  cache_pkt_s                cache_pkt_o;
  logic                      cache_pkt_v_o;
  logic                      cache_pkt_ready_and_i = 1'b0;
  logic [`CA_DATA_WIDTH-1:0] cache_data_i = '0;
  logic                      cache_data_v_i = 1'b0;
  logic                      cache_data_yumi_o;

  // cache model state
  integer      seed = 32'hc1c9_8e5a;
  logic        rand_ready = 1'b0;
  logic [63:0] ret_q[$];
  cache_pkt_s  pkt_log[$];

  // response monitor state
  mem_header_s resp_hdr_q[$];
  logic [63:0] resp_data_q[$];
  int          cmd_total = 0;
  int          resp_total = 0;
  logic        held_v = 1'b0;
  mem_header_s held_hdr;
  logic [63:0] held_data;

  cce_to_cache u_cce_to_cache (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .mem_cmd_header_i      (mem_cmd_header_i),
    .mem_cmd_data_i        (mem_cmd_data_i),
    .mem_cmd_v_i           (mem_cmd_v_i),
    .mem_cmd_ready_and_o   (mem_cmd_ready_and_o),
    .mem_resp_header_o     (mem_resp_header_o),
    .mem_resp_data_o       (mem_resp_data_o),
    .mem_resp_v_o          (mem_resp_v_o),
    .mem_resp_ready_and_i  (mem_resp_ready_and_i),
    .cache_pkt_o           (cache_pkt_o),
    .cache_pkt_v_o         (cache_pkt_v_o),
    .cache_pkt_ready_and_i (cache_pkt_ready_and_i),
    .cache_data_i          (cache_data_i),
    .cache_data_v_i        (cache_data_v_i),
    .cache_data_yumi_o     (cache_data_yumi_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                          input string what);
    if (actual !== expected)
    begin
      $display("Error at %0t ns: %s, got %h expected %h", $time, what, actual, expected);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timed out at %0t ns while waiting for %s", $time, what);
    $display("tests failed");
    $fatal(1);
  endtask

  // one return per accepted packet, in order
  always @(posedge clk_i)
  begin
    logic [31:0] rnd;
    rnd = $random(seed);
    if (reset_i)
    begin
      ret_q.delete();
      cache_data_v_i <= 1'b0;
      cache_pkt_ready_and_i <= 1'b0;
    end
    else
    begin
      if (cache_data_yumi_o && !cache_data_v_i)
      begin
        $display("the DUT took cache data while no return was valid");
        $display("tests failed");
        $fatal(1);
      end
      else if (cache_data_yumi_o)
        void'(ret_q.pop_front());
      if (cache_pkt_v_o && cache_pkt_ready_and_i)
      begin
        ret_q.push_back(64'(cache_pkt_o.addr) ^ RET_XOR);
        pkt_log.push_back(cache_pkt_o);
      end
      cache_pkt_ready_and_i <= rand_ready ? rnd[0] : 1'b1;
      cache_data_v_i <= (ret_q.size() != 0);
      if (ret_q.size() != 0)
        cache_data_i <= ret_q[0];
    end
  end

  always @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      if (mem_cmd_v_i && mem_cmd_ready_and_o)
        cmd_total++;
      if (mem_resp_v_o)
        check_eq(64'(resp_total < cmd_total), 64'd1, "response without outstanding command");
      // a stalled response has to stay put
      if (held_v)
      begin
        check_eq(64'(mem_resp_v_o), 64'd1, "stalled response valid");
        check_eq(64'(mem_resp_header_o), 64'(held_hdr), "stalled response header");
        check_eq(mem_resp_data_o, held_data, "stalled response data");
      end
      if (mem_resp_v_o && mem_resp_ready_and_i)
      begin
        resp_hdr_q.push_back(mem_resp_header_o);
        resp_data_q.push_back(mem_resp_data_o);
        resp_total++;
      end
      held_v    = mem_resp_v_o && !mem_resp_ready_and_i;
      held_hdr  = mem_resp_header_o;
      held_data = mem_resp_data_o;
    end
  end

  function automatic logic [63:0] expected_replicate(input logic [63:0] word,
                                                     input mem_size_e size);
    logic [63:0] out;
    int          nbytes;
    int          i;
    nbytes = 1 << int'(size);
    for (i = 0; i < 8; i++)
      out[8*i +: 8] = word[8*(i % nbytes) +: 8];
    return out;
  endfunction

  function automatic logic [7:0] expected_mask(input mem_header_s hdr);
    logic [7:0] m;
    int         nbytes;
    int         base;
    int         i;
    nbytes = 1 << int'(hdr.size);
    base   = (int'(hdr.addr[2:0]) / nbytes) * nbytes;
    for (i = 0; i < 8; i++)
      m[i] = (i >= base) && (i < base + nbytes);
    return m;
  endfunction

  function automatic cache_opcode_e expected_load_op(input mem_size_e size);
    case (size)
      e_size_1: return LB;
      e_size_2: return LH;
      e_size_4: return LW;
      default:  return LD;
    endcase
  endfunction

  function automatic cache_opcode_e expected_store_op(input mem_size_e size);
    case (size)
      e_size_1: return SB;
      e_size_2: return SH;
      e_size_4: return SW;
      default:  return SD;
    endcase
  endfunction

  function automatic cache_opcode_e expected_amo_op(input mem_subop_e op, input logic word);
    case (op)
      e_amoswap: return word ? AMOSWAP_W : AMOSWAP_D;
      e_amoadd:  return word ? AMOADD_W : AMOADD_D;
      e_amoxor:  return word ? AMOXOR_W : AMOXOR_D;
      e_amoand:  return word ? AMOAND_W : AMOAND_D;
      e_amoor:   return word ? AMOOR_W : AMOOR_D;
      e_amomin:  return word ? AMOMIN_W : AMOMIN_D;
      e_amomax:  return word ? AMOMAX_W : AMOMAX_D;
      e_amominu: return word ? AMOMINU_W : AMOMINU_D;
      default:   return word ? AMOMAXU_W : AMOMAXU_D;
    endcase
  endfunction

  function automatic mem_header_s make_hdr(input mem_msg_type_e t, input mem_subop_e op,
                                           input mem_size_e sz, input logic [27:0] a);
    mem_header_s h;
    h.msg_type = t;
    h.subop    = op;
    h.size     = sz;
    h.addr     = a;
    return h;
  endfunction

  // caller is on a rising edge, returns on the edge of the transfer
  task automatic send_cmd(input mem_header_s hdr, input logic [63:0] data);
    int   cycles;
    logic accepted;
    mem_cmd_header_i <= hdr;
    mem_cmd_data_i   <= data;
    mem_cmd_v_i      <= 1'b1;
    cycles   = 0;
    accepted = 1'b0;
    while (!accepted)
    begin
      if (cycles == WAIT_LIMIT)
        abort_on_timeout("command ready");
      else
      begin
        @(posedge clk_i);
        accepted = mem_cmd_ready_and_o;
        cycles++;
      end
    end
  endtask

  task automatic wait_pkts(input int n);
    int cycles;
    cycles = 0;
    while (pkt_log.size() < n)
    begin
      if (cycles == WAIT_LIMIT)
        abort_on_timeout("cache packets");
      else
      begin
        @(negedge clk_i);
        cycles++;
      end
    end
  endtask

  task automatic wait_resps(input int n);
    int cycles;
    cycles = 0;
    while (resp_hdr_q.size() < n)
    begin
      if (cycles == WAIT_LIMIT)
        abort_on_timeout("memory responses");
      else
      begin
        @(negedge clk_i);
        cycles++;
      end
    end
  endtask

  task automatic wait_returns_drained();
    int cycles;
    cycles = 0;
    while (ret_q.size() != 0 || cache_data_v_i)
    begin
      if (cycles == WAIT_LIMIT)
        abort_on_timeout("tag clear returns to drain");
      else
      begin
        @(negedge clk_i);
        cycles++;
      end
    end
  endtask

  task automatic wait_resp_valid();
    int cycles;
    cycles = 0;
    while (!mem_resp_v_o)
    begin
      if (cycles == WAIT_LIMIT)
        abort_on_timeout("a stalled response");
      else
      begin
        @(negedge clk_i);
        cycles++;
      end
    end
  endtask

  task automatic check_pkt(input mem_header_s hdr, input logic [63:0] data,
                           input cache_opcode_e op);
    cache_pkt_s pkt;
    pkt = pkt_log.pop_front();
    check_eq(64'(pkt.opcode), 64'(op), "packet opcode");
    check_eq(64'(pkt.addr), 64'(hdr.addr), "packet address");
    check_eq(pkt.data, expected_replicate(data, hdr.size), "packet data");
    check_eq(64'(pkt.mask), 64'(expected_mask(hdr)), "packet mask");
  endtask

  task automatic check_resp(input mem_header_s hdr);
    mem_header_s rhdr;
    logic [63:0] rdata;
    rhdr  = resp_hdr_q.pop_front();
    rdata = resp_data_q.pop_front();
    check_eq(64'(rhdr), 64'(hdr), "response header");
    check_eq(rdata, expected_replicate(64'(hdr.addr) ^ RET_XOR, hdr.size), "response data");
  endtask

  task automatic issue_and_check(input mem_header_s hdr, input logic [63:0] data,
                                 input cache_opcode_e op);
    @(posedge clk_i);
    send_cmd(hdr, data);
    mem_cmd_v_i <= 1'b0;
    wait_pkts(1);
    check_pkt(hdr, data, op);
    wait_resps(1);
    check_resp(hdr);
  endtask

  task automatic reset_dut();
    @(posedge clk_i);
    repeat (3)
    begin
      @(negedge clk_i);
      check_eq(64'(mem_cmd_ready_and_o), 64'd0, "command ready in reset");
      check_eq(64'(cache_pkt_v_o), 64'd0, "packet valid in reset");
      check_eq(64'(mem_resp_v_o), 64'd0, "response valid in reset");
      check_eq(64'(cache_data_yumi_o), 64'd0, "data yumi in reset");
      @(posedge clk_i);
    end
    reset_i <= 1'b0;
  endtask

  task automatic test_tag_clear();
    cache_pkt_s pkt;
    int         i;
    wait_pkts(`CA_BLOCKS);
    for (i = 0; i < `CA_BLOCKS; i++)
    begin
      pkt = pkt_log.pop_front();
      check_eq(64'(pkt.opcode), 64'(TAGST), "tag clear opcode");
      check_eq(64'(pkt.addr), 64'(i * `CA_BLOCK_BYTES), "tag clear address");
      check_eq(pkt.data, 64'h0, "tag clear data");
    end
    wait_returns_drained();
    check_eq(64'(pkt_log.size()), 64'd0, "extra tag clear packets");
  endtask

  task automatic test_loads();
    mem_header_s hdr;
    mem_size_e   sz;
    int          s;
    for (s = 0; s < 4; s++)
    begin
      sz  = mem_size_e'(s);
      hdr = make_hdr(s[0] ? e_mem_uc_rd : e_mem_rd, e_store, sz, 28'h012_3400 + 28'(9 * s));
      issue_and_check(hdr, 64'h0, expected_load_op(sz));
    end
  endtask

  task automatic test_stores();
    mem_header_s hdr;
    mem_size_e   sz;
    int          s;
    for (s = 0; s < 4; s++)
    begin
      sz  = mem_size_e'(s);
      hdr = make_hdr(e_mem_wr, e_store, sz, 28'h045_6705 + 28'(8 * s));
      issue_and_check(hdr, 64'hfedc_ba98_7654_3210 ^ 64'(s), expected_store_op(sz));
    end
  endtask

  task automatic test_atomics();
    mem_header_s hdr;
    mem_subop_e  op;
    int          w;
    int          s;
    for (w = 0; w < 2; w++)
    begin
      for (s = 1; s < 10; s++)
      begin
        op  = mem_subop_e'(s);
        hdr = make_hdr(e_mem_amo, op, w == 0 ? e_size_4 : e_size_8,
                       28'h078_9000 + 28'(8 * s + 4 * w));
        issue_and_check(hdr, 64'h1111_2222_3333_4444 + 64'(s), expected_amo_op(op, w == 0));
      end
    end
  endtask

  // four loads in flight, responses stalled for a while
  task automatic test_ordering();
    mem_header_s hdrs[4];
    int          i;
    rand_ready = 1'b1;
    for (i = 0; i < 4; i++)
      hdrs[i] = make_hdr(e_mem_rd, e_store, mem_size_e'(i), 28'h0ab_c000 + 28'(25 * i));
    @(posedge clk_i);
    mem_resp_ready_and_i <= 1'b0;
    for (i = 0; i < 4; i++)
      send_cmd(hdrs[i], 64'h0);
    mem_cmd_v_i <= 1'b0;
    wait_resp_valid();
    repeat (8) @(posedge clk_i);
    mem_resp_ready_and_i <= 1'b1;
    wait_pkts(4);
    for (i = 0; i < 4; i++)
      check_pkt(hdrs[i], 64'h0, expected_load_op(hdrs[i].size));
    wait_resps(4);
    for (i = 0; i < 4; i++)
      check_resp(hdrs[i]);
    rand_ready = 1'b0;
  endtask

  initial
  begin
    reset_i              = 1'b1;
    mem_cmd_header_i     = '0;
    mem_cmd_data_i       = '0;
    mem_cmd_v_i          = 1'b0;
    mem_resp_ready_and_i = 1'b1;
    reset_dut();
    test_tag_clear();
    test_loads();
    test_stores();
    test_atomics();
    test_ordering();
    if (pkt_log.size() == 0 && resp_hdr_q.size() == 0 && cmd_total == resp_total)
    begin
      $display("all tests passed");
      $finish;
    end
    else
    begin
      $display("packets or responses were left over at the end of the run");
      $display("tests failed");
      $fatal(1);
    end
  end

endmodule

//--- src.f
+incdir+.
cache_adapter_pkg.sv
mem_cmd_decode.sv
cache_issue_ctrl.sv
pending_hdr_fifo.sv
mem_resp_pack.sv
cce_to_cache.sv
tb_cce_to_cache.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_cce_to_cache
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_cce_to_cache
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi

exit 0
